//--- common/mul_pkg.sv
// Shared widths, row counts and data types for the pipelined Booth multiply-accumulate unit.
// Imported by every design module that handles operands, rows or the product.
`default_nettype none

package mul_pkg;

  // ---------------------------------------------------------------------------
  // widths
  // ---------------------------------------------------------------------------
  // 32-bit data plus one sign or extension bit
  localparam int OP_W   = 33;
  // accumulated low half and addend
  localparam int LOW_W  = 32;
  // full signed product of two operands
  localparam int PROD_W = 2 * OP_W;
  // multiply-only upper part
  localparam int HI_W   = PROD_W - LOW_W;

  // ---------------------------------------------------------------------------
  // row counts
  // ---------------------------------------------------------------------------
  // 17 booth rows plus the subtract row
  localparam int PP_ROWS  = 18;
  // rows held in the first pipeline register
  localparam int MID_ROWS = 4;

  typedef logic [OP_W-1:0]   operand_t;
  typedef logic [LOW_W-1:0]  addend_t;
  typedef logic [PROD_W-1:0] row_t;

  // overlapping multiplier slice {b(2i+1), b(2i), b(2i-1)}
  typedef logic [2:0] booth_digit_t;

  // upper part from the plain product, lower part from the accumulate path
  typedef struct packed {
    logic [HI_W-1:0]  hi;
    logic [LOW_W-1:0] lo;
  } product_split_t;

  // same word, read flat after a multiply or split after an accumulate
  typedef union packed {
    logic [PROD_W-1:0] full;
    product_split_t    split;
  } product_t;

endpackage

`default_nettype wire

//--- hw/booth/booth_row.sv
// One radix-4 Booth digit applied to the multiplicand.
// Negative digits give the one's complement, with neg as the +1 still owed.
`timescale 1ns/1ps
`default_nettype none

module booth_row
  import mul_pkg::*;
(
  input  operand_t      multiplicand,
  input  booth_digit_t  digit,
  output logic [OP_W:0] pp,
  output logic          neg
);

  logic          sel_one;
  logic          sel_two;
  logic [OP_W:0] mag;

  // digit value is -2*b2 + b1 + b0
  always_comb begin
    sel_one = 1'b0;
    sel_two = 1'b0;
    neg     = 1'b0;
    case (digit)
      3'b001, 3'b010: begin
        sel_one = 1'b1;
      end
      3'b011: begin
        sel_two = 1'b1;
      end
      3'b100: begin
        sel_two = 1'b1;
        neg     = 1'b1;
      end
      3'b101, 3'b110: begin
        sel_one = 1'b1;
        neg     = 1'b1;
      end
      // 000 and 111 are both zero, no correction
      default: begin
        sel_one = 1'b0;
      end
    endcase
  end

  // signed magnitude in op width + 1, so 2x never overflows
  assign mag = sel_two ? {multiplicand, 1'b0} :
               sel_one ? {multiplicand[OP_W-1], multiplicand} :
                         '0;

  assign pp = neg ? ~mag : mag;

endmodule

`default_nettype wire

//--- hw/booth/booth_pp_array.sv
// Builds all partial-product rows of the multiplier, aligned to the product width.
// For multiply-subtract the multiplicand is inverted and the multiplier added as one more row.
`timescale 1ns/1ps
`default_nettype none

module booth_pp_array
  import mul_pkg::*;
(
  input  operand_t multiplicand,
  input  operand_t multiplier,
  input  logic     sub_vld,
  output row_t     rows [PP_ROWS]
);

  localparam int BOOTH_ROWS = PP_ROWS - 1;
  localparam int PP_W       = OP_W + 1;

  operand_t              mcand_sel;
  logic [OP_W+1:0]       mplier_ext;
  logic [PP_W-1:0]       pp [BOOTH_ROWS];
  logic [BOOTH_ROWS-1:0] neg;
  logic                  sub_sign;
  logic [HI_W-1:0]       sub_hi;

  // a - b*c rewritten as ~b*c + c, so only the multiplicand flips here
  assign mcand_sel = sub_vld ? ~multiplicand : multiplicand;

  // implicit zero below bit 0, sign repeated above the top bit
  assign mplier_ext = {multiplier[OP_W-1], multiplier, 1'b0};

  // ---------------------------------------------------------------------------
  // booth rows
  // ---------------------------------------------------------------------------
  for (genvar i = 0; i < BOOTH_ROWS; i++) begin : g_row
    row_t ext;
    row_t corr;

    booth_row i_booth_row (
      .multiplicand (mcand_sel),
      .digit        (mplier_ext[2*i+2 -: 3]),
      .pp           (pp[i]),
      .neg          (neg[i])
    );

    assign ext = {{(PROD_W-PP_W){pp[i][PP_W-1]}}, pp[i]};

    // the previous row's +1 sits in the two free bits below this shift
    if (i == 0) begin : g_first
      assign corr = '0;
    end else begin : g_next
      assign corr = row_t'(neg[i-1]) << (2*i - 2);
    end

    assign rows[i] = (ext << (2*i)) | corr;
  end

  // ---------------------------------------------------------------------------
  // subtract row
  // ---------------------------------------------------------------------------
  // the top digit's +1 lands at bit 32, which is also where the
  // multiplier's sign weight starts; merge both into the upper field
  assign sub_sign = sub_vld & multiplier[OP_W-1];

  always_comb begin
    case ({sub_sign, neg[BOOTH_ROWS-1]})
      2'b01:   sub_hi = HI_W'(1);
      2'b10:   sub_hi = '1;
      default: sub_hi = '0;
    endcase
  end

  assign rows[PP_ROWS-1] = {sub_hi, (sub_vld ? multiplier[LOW_W-1:0] : {LOW_W{1'b0}})};

endmodule

`default_nettype wire

//--- hw/tree/csa_tree.sv
// Carry-save reduction of ROWS_IN rows to ROWS_OUT rows by layers of 3:2 adders.
// The row total is kept modulo 2^PROD_W; carry rows come out already shifted.
`timescale 1ns/1ps
`default_nettype none

module csa_tree
  import mul_pkg::*;
#(
  parameter int ROWS_IN  = 18,
  parameter int ROWS_OUT = 4
) (
  input  row_t rows_in  [ROWS_IN],
  output row_t rows_out [ROWS_OUT]
);

  // groups compressed at a layer with n rows, never going below ROWS_OUT
  function automatic int groups_at(input int n);
    int g;
    g = n / 3;
    if (g > n - ROWS_OUT) begin
      g = n - ROWS_OUT;
    end
    return g;
  endfunction

  function automatic int rows_after(input int layers);
    int n;
    int l;
    n = ROWS_IN;
    l = 0;
    while (l < layers) begin
      n = n - groups_at(n);
      l = l + 1;
    end
    return n;
  endfunction

  function automatic int layer_count();
    int n;
    int l;
    n = ROWS_IN;
    l = 0;
    while (n > ROWS_OUT && groups_at(n) > 0) begin
      n = n - groups_at(n);
      l = l + 1;
    end
    return l;
  endfunction

  localparam int NUM_LAYERS = layer_count();

  // layer 0 is the input, unused slots of a layer are tied low
  wire row_t lyr [NUM_LAYERS+1][ROWS_IN];

  for (genvar r = 0; r < ROWS_IN; r++) begin : g_in
    assign lyr[0][r] = rows_in[r];
  end

  for (genvar l = 0; l < NUM_LAYERS; l++) begin : g_layer
    localparam int N_IN  = rows_after(l);
    localparam int GRP   = groups_at(N_IN);
    localparam int N_OUT = N_IN - GRP;

    for (genvar g = 0; g < GRP; g++) begin : g_csa
      row_t a;
      row_t b;
      row_t c;
      assign a = lyr[l][3*g];
      assign b = lyr[l][3*g+1];
      assign c = lyr[l][3*g+2];
      assign lyr[l+1][2*g]   = a ^ b ^ c;
      assign lyr[l+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;
    end

    // leftover rows skip this layer
    for (genvar p = 3*GRP; p < N_IN; p++) begin : g_pass
      assign lyr[l+1][p-GRP] = lyr[l][p];
    end

    for (genvar z = N_OUT; z < ROWS_IN; z++) begin : g_pad
      assign lyr[l+1][z] = '0;
    end
  end

  for (genvar r = 0; r < ROWS_OUT; r++) begin : g_out
    assign rows_out[r] = lyr[NUM_LAYERS][r];
  end

endmodule

`default_nettype wire

//--- hw/mul_stage1.sv
// First pipeline stage: Booth partial products, reduction to four rows, stage-1 register.
// The register loads on pipe1_down and holds otherwise.
`timescale 1ns/1ps
`default_nettype none

module mul_stage1
  import mul_pkg::*;
(
  input  logic     pipe1_clk,
  input  logic     cpurst_b,
  input  logic     pipe1_down,
  input  operand_t multiplicand,
  input  operand_t multiplier,
  input  logic     sub_vld,
  output row_t     stage1_rows [MID_ROWS]
);

  row_t pp_rows  [PP_ROWS];
  row_t mid_rows [MID_ROWS];

  booth_pp_array i_booth_pp_array (
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .sub_vld      (sub_vld),
    .rows         (pp_rows)
  );

  // 18 -> 12 -> 8 -> 6 -> 4
  csa_tree #(
    .ROWS_IN  (PP_ROWS),
    .ROWS_OUT (MID_ROWS)
  ) i_csa_tree (
    .rows_in  (pp_rows),
    .rows_out (mid_rows)
  );

  // ---------------------------------------------------------------------------
  // stage-1 register
  // ---------------------------------------------------------------------------
  always_ff @(posedge pipe1_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      stage1_rows <= '{default: '0};
    end else if (pipe1_down) begin
      stage1_rows <= mid_rows;
    end
  end

endmodule

`default_nettype wire

//--- hw/mul_stage2.sv
// Second pipeline stage: reduction to sum and carry, stage-2 register with the addend,
// and the final adders for the upper product half and the accumulated low half.
`timescale 1ns/1ps
`default_nettype none

module mul_stage2
  import mul_pkg::*;
(
  input  logic     pipe1_clk,
  input  logic     cpurst_b,
  input  logic     pipe2_down,
  input  row_t     stage1_rows [MID_ROWS],
  input  addend_t  addend,
  output product_t product
);

  row_t       sc_rows [2];
  row_t       sum_q;
  row_t       carry_q;
  addend_t    addend_q;
  row_t       prod_full;
  logic [LOW_W-1:0] acc_s;
  logic [LOW_W-1:0] acc_c;
  logic [LOW_W-1:0] acc_lo;

  // 4 -> 3 -> 2
  csa_tree #(
    .ROWS_IN  (MID_ROWS),
    .ROWS_OUT (2)
  ) i_csa_tree (
    .rows_in  (stage1_rows),
    .rows_out (sc_rows)
  );

  // ---------------------------------------------------------------------------
  // stage-2 register
  // ---------------------------------------------------------------------------
  // addend joins here, one stage after the operands
  always_ff @(posedge pipe1_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      sum_q    <= '0;
      carry_q  <= '0;
      addend_q <= '0;
    end else if (pipe2_down) begin
      sum_q    <= sc_rows[0];
      carry_q  <= sc_rows[1];
      addend_q <= addend;
    end
  end

  // ---------------------------------------------------------------------------
  // final adders
  // ---------------------------------------------------------------------------
  // pure product, only its upper part is used
  assign prod_full = sum_q + carry_q;

  // low half: one 3:2 step folds in the addend
  assign acc_s  = sum_q[LOW_W-1:0] ^ carry_q[LOW_W-1:0] ^ addend_q;
  assign acc_c  = (sum_q[LOW_W-1:0] & carry_q[LOW_W-1:0]) |
                  (sum_q[LOW_W-1:0] & addend_q) |
                  (carry_q[LOW_W-1:0] & addend_q);
  assign acc_lo = acc_s + {acc_c[LOW_W-2:0], 1'b0};

  always_comb begin
    product.split.hi = prod_full[PROD_W-1:LOW_W];
    product.split.lo = acc_lo;
  end

endmodule

`default_nettype wire

//--- hw/booth_mac.sv
// Top level of the two-stage Booth multiply-add/subtract unit.
// Result is valid two captures after the operands, addend joins at the second.
`timescale 1ns/1ps
`default_nettype none

module booth_mac
  import mul_pkg::*;
(
  input  logic     pipe1_clk,
  input  logic     cpurst_b,
  input  operand_t multiplicand,
  input  operand_t multiplier,
  input  logic     sub_vld,
  input  addend_t  addend,
  input  logic     pipe1_down,
  input  logic     pipe2_down,
  output product_t product
);

  // carry-save rows between the two stage registers
  row_t stage1_rows [MID_ROWS];

  mul_stage1 i_mul_stage1 (
    .pipe1_clk    (pipe1_clk),
    .cpurst_b     (cpurst_b),
    .pipe1_down   (pipe1_down),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .sub_vld      (sub_vld),
    .stage1_rows  (stage1_rows)
  );

  mul_stage2 i_mul_stage2 (
    .pipe1_clk   (pipe1_clk),
    .cpurst_b    (cpurst_b),
    .pipe2_down  (pipe2_down),
    .stage1_rows (stage1_rows),
    .addend      (addend),
    .product     (product)
  );

endmodule

`default_nettype wire

//--- tb/booth_mac_properties.sv
// Concurrent checks on the multiply-add product, bound to the top level.
// Covers the reset value, hold under a low stage-2 enable and unknown bits.
`timescale 1ns/1ps
`default_nettype none

module booth_mac_properties
  import mul_pkg::*;
(
  input logic     pipe1_clk,
  input logic     cpurst_b,
  input logic     pipe2_down,
  input product_t product
);

  int fail_count = 0;

  // registers clear asynchronously, so zero shows at every edge in reset
  a_reset_zero: assert property (@(posedge pipe1_clk) !cpurst_b |-> product.full == '0)
    else begin
      $error("product is not zero while reset is held");
      fail_count++;
    end

  // stage-2 register holds, and product is combinational from it
  a_hold_stable: assert property (@(posedge pipe1_clk) disable iff (!cpurst_b)
                                  !pipe2_down |=> $stable(product))
    else begin
      $error("product changed after an edge with pipe2_down low");
      fail_count++;
    end

  a_known: assert property (@(posedge pipe1_clk) disable iff (!cpurst_b)
                            !$isunknown(product))
    else begin
      $error("product has unknown bits after reset");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tb/tb_booth_mac.sv
// Directed testbench for the two-stage Booth multiply-add/subtract unit.
// Runs corner, accumulate, streaming and stall cases against a model of the product rules.
`timescale 1ns/1ps
`default_nettype none

module tb_booth_mac
  import mul_pkg::*;
();

  localparam int STREAM_LEN  = 24;
  localparam int DIRECT_RUNS = 24;
  // three edges per directed item plus reset, stream drain and stall
  localparam int TIMEOUT_CYC = 2 * (3 + 3 * DIRECT_RUNS + STREAM_LEN + 2 + 12);

  logic        pipe1_clk;
  logic        cpurst_b;
  operand_t    multiplicand;
  operand_t    multiplier;
  logic        sub_vld;
  addend_t     addend;
  logic        pipe1_down;
  logic        pipe2_down;
  product_t    product;
  logic [31:0] lfsr_state;
  int          err_cnt;
  int          cycle_cnt;
  int          assert_fails;

  booth_mac i_booth_mac (
    .pipe1_clk    (pipe1_clk),
    .cpurst_b     (cpurst_b),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .sub_vld      (sub_vld),
    .addend       (addend),
    .pipe1_down   (pipe1_down),
    .pipe2_down   (pipe2_down),
    .product      (product)
  );

  bind booth_mac booth_mac_properties i_booth_mac_properties (
    .pipe1_clk  (pipe1_clk),
    .cpurst_b   (cpurst_b),
    .pipe2_down (pipe2_down),
    .product    (product)
  );

  always #20 pipe1_clk = ~pipe1_clk;

  always @(posedge pipe1_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // random source and reference model
  // ---------------------------------------------------------------------------
  // taps 32, 22, 2, 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    next_bit = lfsr_state[31];
    lfsr_state = {lfsr_state[30:0], fb};
  endfunction

  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], next_bit()};
    end
    return r;
  endfunction

  // P is +/- a*b mod 2^66
  // hi comes from P and lo is addend + P mod 2^32
  function automatic product_t model_result(input operand_t a, input operand_t b,
                                            input logic sub, input addend_t ad);
    logic signed [PROD_W-1:0] sa;
    logic signed [PROD_W-1:0] sb;
    logic [PROD_W-1:0]        p;
    product_t                 r;
    sa = {{(PROD_W-OP_W){a[OP_W-1]}}, a};
    sb = {{(PROD_W-OP_W){b[OP_W-1]}}, b};
    p = sa * sb;
    if (sub) begin
      p = -p;
    end
    r.split.hi = p[PROD_W-1:LOW_W];
    r.split.lo = ad + p[LOW_W-1:0];
    return r;
  endfunction

  task automatic check_full(input string name, input product_t expected,
                            input product_t actual);
    if (actual.full !== expected.full) begin
      err_cnt++;
      $display("error %s: expected %h, actual %h", name, expected.full, actual.full);
    end
  endtask

  task automatic check_split(input string name, input product_t expected,
                             input product_t actual);
    if (actual.split.hi !== expected.split.hi) begin
      err_cnt++;
      $display("error %s hi: expected %h, actual %h", name, expected.split.hi,
               actual.split.hi);
    end
    if (actual.split.lo !== expected.split.lo) begin
      err_cnt++;
      $display("error %s lo: expected %h, actual %h", name, expected.split.lo,
               actual.split.lo);
    end
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------
  task automatic drive_ops(input operand_t a, input operand_t b, input logic sub);
    multiplicand <= a;
    multiplier   <= b;
    sub_vld      <= sub;
  endtask

  // operands go in one edge ahead of the addend
  task automatic mac_item(input string name, input operand_t a, input operand_t b,
                          input logic sub, input addend_t ad, input logic flat);
    product_t expected;
    expected = model_result(a, b, sub, ad);
    @(posedge pipe1_clk);
    drive_ops(a, b, sub);
    @(posedge pipe1_clk);
    addend <= ad;
    @(posedge pipe1_clk);
    @(negedge pipe1_clk);
    if (flat) begin
      check_full(name, expected, product);
    end else begin
      check_split(name, expected, product);
    end
  endtask

  task automatic corner_products();
    operand_t c [7];
    c = '{33'h0_0000_0000, 33'h0_0000_0001, 33'h1_ffff_ffff, 33'h0_ffff_ffff,
          33'h1_0000_0000, 33'h0_aaaa_aaaa, 33'h1_5555_5555};
    for (int i = 0; i < 7; i++) begin
      mac_item("mul_corner", c[i], c[6-i], 1'b0, '0, 1'b1);
      mac_item("mul_square", c[i], c[i], 1'b0, '0, 1'b1);
    end
  endtask

  task automatic accumulate_items(input string name, input logic sub);
    mac_item(name, 33'h1_0000_0000, 33'h1_0000_0000, sub, 32'hffff_ffff, 1'b0);
    mac_item(name, 33'h1_ffff_ffff, 33'h0_ffff_ffff, sub, 32'h8000_0001, 1'b0);
    repeat (3) begin
      mac_item(name, operand_t'(random_bits(OP_W)), operand_t'(random_bits(OP_W)), sub,
               addend_t'(random_bits(LOW_W)), 1'b0);
    end
  endtask

  // each result is checked two edges after its operands
  task automatic stream_items();
    product_t expected_q [$];
    addend_t  addend_q [$];
    operand_t a;
    operand_t b;
    logic     sub;
    addend_t  ad;
    for (int t = 0; t < STREAM_LEN + 2; t++) begin
      @(posedge pipe1_clk);
      if (t < STREAM_LEN) begin
        a = operand_t'(random_bits(OP_W));
        b = operand_t'(random_bits(OP_W));
        sub = next_bit();
        ad = addend_t'(random_bits(LOW_W));
        drive_ops(a, b, sub);
        expected_q.push_back(model_result(a, b, sub, ad));
        addend_q.push_back(ad);
      end
      if (t >= 1 && t <= STREAM_LEN) begin
        addend <= addend_q.pop_front();
      end
      @(negedge pipe1_clk);
      if (t >= 2) begin
        check_split("stream", expected_q.pop_front(), product);
      end
    end
  endtask

  task automatic stall_sequence();
    product_t first_res;
    product_t held_res;
    first_res = model_result(33'h0_1234_5678, 33'h1_fedc_ba98, 1'b0, 32'h0bad_cafe);
    held_res = model_result(33'h1_8765_4321, 33'h0_7777_0001, 1'b1, 32'h1357_9bdf);
    mac_item("stall_first", 33'h0_1234_5678, 33'h1_fedc_ba98, 1'b0, 32'h0bad_cafe, 1'b0);
    @(posedge pipe1_clk);
    pipe2_down <= 1'b0;
    drive_ops(33'h1_8765_4321, 33'h0_7777_0001, 1'b1);
    // held item sits in stage 1 while the inputs change underneath
    @(posedge pipe1_clk);
    pipe1_down <= 1'b0;
    addend <= 32'h1357_9bdf;
    drive_ops(33'h0_dead_beef, 33'h1_0f0f_0f0f, 1'b0);
    repeat (3) begin
      @(negedge pipe1_clk);
      check_split("stall_hold", first_res, product);
      @(posedge pipe1_clk);
    end
    pipe2_down <= 1'b1;
    // first capture with stage 2 enabled again
    @(posedge pipe1_clk);
    @(negedge pipe1_clk);
    check_split("stall_release", held_res, product);
    // stage 2 takes the same held rows once more
    @(posedge pipe1_clk);
    @(negedge pipe1_clk);
    check_split("stall_retake", held_res, product);
    @(posedge pipe1_clk);
    pipe1_down <= 1'b1;
  endtask

  initial begin
    lfsr_state   = 32'h9c9f516b;
    err_cnt      = 0;
    cycle_cnt    = 0;
    pipe1_clk    = 1'b0;
    cpurst_b     = 1'b0;
    multiplicand = '0;
    multiplier   = '0;
    sub_vld      = 1'b0;
    addend       = '0;
    pipe1_down   = 1'b1;
    pipe2_down   = 1'b1;
    repeat (2) @(posedge pipe1_clk);
    cpurst_b <= 1'b1;
    @(negedge pipe1_clk);
    check_full("reset", '0, product);
    corner_products();
    accumulate_items("mul_add", 1'b0);
    accumulate_items("mul_sub", 1'b1);
    stream_items();
    stall_sequence();
    @(negedge pipe1_clk);
    assert_fails = i_booth_mac.i_booth_mac_properties.fail_count;
    $display("errors: %0d result, %0d assertion", err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/mul_pkg.sv
hw/booth/booth_row.sv
hw/booth/booth_pp_array.sv
hw/tree/csa_tree.sv
hw/mul_stage1.sv
hw/mul_stage2.sv
hw/booth_mac.sv
tb/booth_mac_properties.sv
tb/tb_booth_mac.sv
